// File: all.f
+incdir+logic
logic/pipe_pkg.sv
logic/pipe_reg.sv
logic/bus_arbiter.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline.sv
testbench/tb_memory.sv
testbench/pipeline_chk.sv
testbench/pipeline_tb.sv

// File: logic/bus_arbiter.sv
/* Shares the one memory bus between instruction fetch and data access
   Data wins when idle; the grant stays locked until the valid pulse */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module bus_arbiter (
  input  logic                    clock,
  input  logic                    reset,
  // Fetch side
  input  pipe_pkg::bus_cmd_e      fetch_cmd,
  input  logic [`PIPE_DATA_W-1:0] fetch_addr,
  output logic                    fetch_valid,
  // Data side
  input  pipe_pkg::bus_cmd_e      data_cmd,
  input  logic [`PIPE_DATA_W-1:0] data_addr,
  input  logic [`PIPE_DATA_W-1:0] data_wdata,
  output logic                    data_valid,
  // Bus side
  output pipe_pkg::bus_cmd_e      bus_cmd,
  output logic [`PIPE_DATA_W-1:0] bus_addr,
  output logic [`PIPE_DATA_W-1:0] bus_wdata,
  input  logic                    bus_valid
);

  logic locked;        // Access in flight
  logic locked_data;   // Owner of that access
  logic grant_data;

  assign grant_data = locked ? locked_data : (data_cmd != pipe_pkg::BUS_NONE);

  assign bus_cmd   = grant_data ? data_cmd  : fetch_cmd;
  assign bus_addr  = grant_data ? data_addr : fetch_addr;
  assign bus_wdata = grant_data ? data_wdata : '0;

  // Valid only to the owner
  assign data_valid  = bus_valid && grant_data;
  assign fetch_valid = bus_valid && !grant_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      locked      <= 1'b0;
      locked_data <= 1'b0;
    end else if (bus_valid) begin
      locked <= 1'b0;                          // Access done
    end else if (bus_cmd != pipe_pkg::BUS_NONE) begin
      locked      <= 1'b1;
      locked_data <= grant_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
/* Decode: field split, operand read and immediate sign extension
   Holds the register file, written from the MEM/WB packet */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module decode_stage (
  input  logic              clock,
  input  logic              reset,
  input  pipe_pkg::if_id_t  if_id_packet,
  input  pipe_pkg::mem_wb_t wb_packet,
  output pipe_pkg::id_ex_t  id_packet
);

  logic [`PIPE_DATA_W-1:0]    regs [`PIPE_NUM_REGS];
  logic [`PIPE_DATA_W-1:0]    inst;
  logic [`PIPE_REG_IDX_W-1:0] rd;
  logic [`PIPE_REG_IDX_W-1:0] ra;
  logic [`PIPE_REG_IDX_W-1:0] rb;

  assign inst = if_id_packet.inst;
  assign rd   = inst[25:21];
  assign ra   = inst[20:16];
  assign rb   = inst[15:11];

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    id_packet          = '0;
    id_packet.valid    = if_id_packet.valid;
    id_packet.pc       = if_id_packet.pc;
    id_packet.opcode   = pipe_pkg::opcode_e'(inst[31:26]);
    id_packet.dest_idx = rd;
    id_packet.rs_a     = (ra == '0) ? '0 : regs[ra];   // r0 reads zero
    id_packet.rs_b     = (rb == '0) ? '0 : regs[rb];
    id_packet.imm      = {{(`PIPE_DATA_W-16){inst[15]}}, inst[15:0]};
    case (id_packet.opcode)
      pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
      pipe_pkg::OP_OR, pipe_pkg::OP_XOR, pipe_pkg::OP_ADDI,
      pipe_pkg::OP_LOAD: begin
        // A write to r0 is dropped here
        id_packet.wr_en = if_id_packet.valid && (rd != '0);
      end
      pipe_pkg::OP_NOP, pipe_pkg::OP_STORE: begin
        id_packet.wr_en = 1'b0;
      end
      pipe_pkg::OP_HALT: begin
        id_packet.halt = if_id_packet.valid;
      end
      default: begin
        id_packet.illegal = if_id_packet.valid;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////
  // Programs start from all-zero registers
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `PIPE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_packet.valid && wb_packet.wr_en && wb_packet.dest_idx != '0) begin
      regs[wb_packet.dest_idx] <= wb_packet.result;   // Never r0
    end
  end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
/* Execute: ALU operations and load/store effective address
   Purely combinational between id_ex and ex_mem */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module execute_stage (
  input  pipe_pkg::id_ex_t  id_ex_packet,
  output pipe_pkg::ex_mem_t ex_packet
);

  logic [`PIPE_DATA_W-1:0] a;
  logic [`PIPE_DATA_W-1:0] b;
  logic [`PIPE_DATA_W-1:0] imm;

  assign a   = id_ex_packet.rs_a;
  assign b   = id_ex_packet.rs_b;
  assign imm = id_ex_packet.imm;

  always_comb begin
    ex_packet            = '0;
    ex_packet.valid      = id_ex_packet.valid;
    ex_packet.pc         = id_ex_packet.pc;
    ex_packet.store_data = b;                     // rb for STORE
    ex_packet.dest_idx   = id_ex_packet.dest_idx;
    ex_packet.wr_en      = id_ex_packet.wr_en;
    ex_packet.halt       = id_ex_packet.halt;
    ex_packet.illegal    = id_ex_packet.illegal;
    ex_packet.load       = id_ex_packet.valid && id_ex_packet.opcode == pipe_pkg::OP_LOAD;
    ex_packet.store      = id_ex_packet.valid && id_ex_packet.opcode == pipe_pkg::OP_STORE;

    // ALU
    case (id_ex_packet.opcode)
      pipe_pkg::OP_ADD:   ex_packet.result = a + b;
      pipe_pkg::OP_SUB:   ex_packet.result = a - b;
      pipe_pkg::OP_AND:   ex_packet.result = a & b;
      pipe_pkg::OP_OR:    ex_packet.result = a | b;
      pipe_pkg::OP_XOR:   ex_packet.result = a ^ b;
      pipe_pkg::OP_ADDI,
      pipe_pkg::OP_LOAD,
      pipe_pkg::OP_STORE: ex_packet.result = a + imm;   // Address for memory ops
      default:            ex_packet.result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
/* Instruction fetch: PC register and bus request for the word at the PC
   Parks a word that arrives during a stall; stops after HALT or illegal */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module fetch_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  output pipe_pkg::bus_cmd_e      fetch_cmd,
  output logic [`PIPE_DATA_W-1:0] fetch_addr,
  input  logic                    fetch_valid,
  input  logic [`PIPE_DATA_W-1:0] fetch_data,
  output pipe_pkg::if_id_t        if_packet
);

  typedef enum logic [1:0] {FS_WAIT, FS_RUN, FS_STOP} fetch_state_e;

  fetch_state_e            state;
  logic [`PIPE_DATA_W-1:0] pc;
  logic                    held_valid;   // Word parked by a stall
  logic [`PIPE_DATA_W-1:0] held_inst;
  logic [`PIPE_DATA_W-1:0] word;
  logic                    word_valid;
  logic                    accept;
  logic                    stop_word;

  assign word_valid = held_valid || fetch_valid;
  assign word       = held_valid ? held_inst : fetch_data;
  assign accept     = word_valid && !stall;     // if_id takes it at this edge
  assign stop_word  = word[31:26] >= pipe_pkg::OP_HALT;  // HALT or above

  // No new request while a word is parked
  assign fetch_cmd  = (state == FS_RUN && !held_valid) ? pipe_pkg::BUS_LOAD
                                                       : pipe_pkg::BUS_NONE;
  assign fetch_addr = pc;

  assign if_packet  = '{valid: word_valid, pc: pc, inst: word};

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= FS_WAIT;
      pc         <= `PIPE_PC_RESET;
      held_valid <= 1'b0;
    end else begin
      if (state == FS_WAIT) begin
        state <= FS_RUN;                // First request a cycle after reset
      end
      if (accept) begin
        pc         <= pc + 'd4;
        held_valid <= 1'b0;
        if (stop_word) begin
          state <= FS_STOP;             // Until reset
        end
      end else if (fetch_valid) begin
        held_valid <= 1'b1;             // Stalled, keep the word
      end
    end
  end

  // Payload only
  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      held_inst <= fetch_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
/* Memory access: drives the data request and stalls until the valid pulse
   Picks load data or the ALU result as the writeback value */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module memory_stage (
  input  pipe_pkg::ex_mem_t       ex_mem_packet,
  output pipe_pkg::bus_cmd_e      data_cmd,
  output logic [`PIPE_DATA_W-1:0] data_addr,
  output logic [`PIPE_DATA_W-1:0] data_wdata,
  input  logic                    data_valid,
  input  logic [`PIPE_DATA_W-1:0] data_rdata,
  output logic                    stall,
  output pipe_pkg::mem_wb_t       mem_packet
);

  logic mem_access;

  assign mem_access = ex_mem_packet.valid && (ex_mem_packet.load || ex_mem_packet.store);

  ////////////////////////////////////////////////////////////
  // Data request, held while the packet sits in ex_mem
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (!mem_access) begin
      data_cmd = pipe_pkg::BUS_NONE;
    end else if (ex_mem_packet.load) begin
      data_cmd = pipe_pkg::BUS_LOAD;
    end else begin
      data_cmd = pipe_pkg::BUS_STORE;
    end
  end

  assign data_addr  = ex_mem_packet.result;
  assign data_wdata = ex_mem_packet.store_data;
  assign stall      = mem_access && !data_valid;   // Low in the valid cycle

  // Writeback packet
  always_comb begin
    mem_packet          = '0;
    mem_packet.valid    = ex_mem_packet.valid;
    mem_packet.pc       = ex_mem_packet.pc;
    mem_packet.dest_idx = ex_mem_packet.dest_idx;
    mem_packet.result   = ex_mem_packet.load ? data_rdata : ex_mem_packet.result;
    mem_packet.wr_en    = ex_mem_packet.wr_en;     // Clear for STORE
    mem_packet.halt     = ex_mem_packet.halt;
    mem_packet.illegal  = ex_mem_packet.illegal;
  end

endmodule

`default_nettype wire

// File: logic/pipe_macros.svh
/* Widths, counts and reset values shared by the pipeline RTL
   Include wherever one of them is needed */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////
`define PIPE_DATA_W     32             // Data and address width

////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////
`define PIPE_NUM_REGS   32             // Architectural registers
`define PIPE_REG_IDX_W  5              // Register index width

// First fetch address after reset
`define PIPE_PC_RESET   32'h0000_0000

`endif

// File: logic/pipe_pkg.sv
/* Opcodes, bus commands, status codes and the stage packets
   Referenced everywhere through pipe_pkg:: scoped names */
`default_nettype none
`include "pipe_macros.svh"

package pipe_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction format, fixed 32 bits
  //   [31:26] opcode  [25:21] rd  [20:16] ra  [15:11] rb
  //   [15:0]  signed immediate, overlapping rb
  // LOAD   rd <= mem[ra + imm]
  // STORE  mem[ra + imm] <= rb
  ////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    OP_NOP   = 6'd0,
    OP_ADD   = 6'd1,
    OP_SUB   = 6'd2,
    OP_AND   = 6'd3,
    OP_OR    = 6'd4,
    OP_XOR   = 6'd5,
    OP_ADDI  = 6'd6,
    OP_LOAD  = 6'd7,
    OP_STORE = 6'd8,
    OP_HALT  = 6'd9     // Highest legal code
  } opcode_e;           // Any unlisted value is illegal

  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_cmd_e;

  typedef enum logic [1:0] {
    NO_ERROR          = 2'd0,
    HALTED_ON_HALT    = 2'd1,
    HALTED_ON_ILLEGAL = 2'd2
  } error_code_e;

  ////////////////////////////////////////////////////////////
  // Stage packets
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                      valid;
    logic [`PIPE_DATA_W-1:0]   pc;
    logic [`PIPE_DATA_W-1:0]   inst;
  } if_id_t;

  typedef struct packed {
    logic                      valid;
    logic [`PIPE_DATA_W-1:0]   pc;
    opcode_e                   opcode;
    logic [`PIPE_REG_IDX_W-1:0] dest_idx;
    logic [`PIPE_DATA_W-1:0]   rs_a;      // Value of ra
    logic [`PIPE_DATA_W-1:0]   rs_b;      // Value of rb
    logic [`PIPE_DATA_W-1:0]   imm;       // Sign extended
    logic                      wr_en;
    logic                      halt;
    logic                      illegal;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    logic [`PIPE_DATA_W-1:0]   pc;
    logic [`PIPE_DATA_W-1:0]   result;     // ALU result or address
    logic [`PIPE_DATA_W-1:0]   store_data;
    logic [`PIPE_REG_IDX_W-1:0] dest_idx;
    logic                      wr_en;
    logic                      load;
    logic                      store;
    logic                      halt;
    logic                      illegal;
  } ex_mem_t;

  typedef struct packed {
    logic                      valid;
    logic [`PIPE_DATA_W-1:0]   pc;
    logic [`PIPE_REG_IDX_W-1:0] dest_idx;
    logic [`PIPE_DATA_W-1:0]   result;
    logic                      wr_en;
    logic                      halt;
    logic                      illegal;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: logic/pipe_reg.sv
/* Pipeline register for any stage packet
   Holds when enable is low; bubble loads the empty packet */
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type      payload_t   = logic,
  parameter payload_t reset_value = '0     // Empty packet, valid clear
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     enable,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clock) begin
    if (reset) begin
      q <= reset_value;
    end else if (bubble) begin   // Bubble wins over enable
      q <= reset_value;
    end else if (enable) begin
      q <= d;
    end                          // Else hold
  end

endmodule

`default_nettype wire

// File: logic/pipeline.sv
/* Top of the five-stage pipeline: stages, packet registers, bus arbiter
   Commit outputs and halt status are taken from the MEM/WB packet */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module pipeline (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       mem2proc_valid,
  input  logic [`PIPE_DATA_W-1:0]    mem2proc_data,
  output pipe_pkg::bus_cmd_e         proc2mem_command,
  output logic [`PIPE_DATA_W-1:0]    proc2mem_addr,
  output logic [`PIPE_DATA_W-1:0]    proc2mem_data,
  output logic [`PIPE_DATA_W-1:0]    completed_insts,
  output pipe_pkg::error_code_e      error_status,
  output logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx,
  output logic [`PIPE_DATA_W-1:0]    commit_wr_data,
  output logic                       commit_wr_en,
  output logic [`PIPE_DATA_W-1:0]    commit_pc
);

  pipe_pkg::if_id_t  if_packet, if_id_packet;
  pipe_pkg::id_ex_t  id_packet, id_ex_packet;
  pipe_pkg::ex_mem_t ex_packet, ex_mem_packet;
  pipe_pkg::mem_wb_t mem_packet, mem_wb_packet;

  logic                    stall;        // Memory stage waiting on the bus
  pipe_pkg::bus_cmd_e      fetch_cmd, data_cmd;
  logic [`PIPE_DATA_W-1:0] fetch_addr, data_addr, data_wdata;
  logic                    fetch_valid, data_valid;
  pipe_pkg::error_code_e   error_q, error_now;

  ////////////////////////////////////////////////////////////
  // Bus sharing
  ////////////////////////////////////////////////////////////
  bus_arbiter arbiter0 (
    .clock, .reset,
    .fetch_cmd, .fetch_addr, .fetch_valid,
    .data_cmd, .data_addr, .data_wdata, .data_valid,
    .bus_cmd   (proc2mem_command),
    .bus_addr  (proc2mem_addr),
    .bus_wdata (proc2mem_data),
    .bus_valid (mem2proc_valid)
  );

  ////////////////////////////////////////////////////////////
  // Stages and packet registers
  ////////////////////////////////////////////////////////////
  fetch_stage fetch0 (
    .clock, .reset, .stall,
    .fetch_cmd, .fetch_addr, .fetch_valid,
    .fetch_data (mem2proc_data),
    .if_packet
  );

  pipe_reg #(.payload_t(pipe_pkg::if_id_t)) if_id_reg (
    .clock, .reset, .enable(!stall), .bubble(1'b0), .d(if_packet), .q(if_id_packet)
  );

  decode_stage decode0 (
    .clock, .reset, .if_id_packet,
    .wb_packet (mem_wb_packet),   // Register file write port
    .id_packet
  );

  pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_reg (
    .clock, .reset, .enable(!stall), .bubble(1'b0), .d(id_packet), .q(id_ex_packet)
  );

  execute_stage execute0 (.id_ex_packet, .ex_packet);

  pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_reg (
    .clock, .reset, .enable(!stall), .bubble(1'b0), .d(ex_packet), .q(ex_mem_packet)
  );

  memory_stage memory0 (
    .ex_mem_packet,
    .data_cmd, .data_addr, .data_wdata, .data_valid,
    .data_rdata (mem2proc_data),
    .stall,
    .mem_packet
  );

  // Bubble while stalled so nothing commits twice
  pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_reg (
    .clock, .reset, .enable(1'b1), .bubble(stall), .d(mem_packet), .q(mem_wb_packet)
  );

  ////////////////////////////////////////////////////////////
  // Commit and status
  ////////////////////////////////////////////////////////////
  assign commit_wr_en   = mem_wb_packet.valid && mem_wb_packet.wr_en;
  assign commit_wr_idx  = mem_wb_packet.dest_idx;
  assign commit_wr_data = mem_wb_packet.result;
  assign commit_pc      = mem_wb_packet.pc;

  always_comb begin
    if (mem_wb_packet.valid && mem_wb_packet.illegal) begin
      error_now = pipe_pkg::HALTED_ON_ILLEGAL;
    end else if (mem_wb_packet.valid && mem_wb_packet.halt) begin
      error_now = pipe_pkg::HALTED_ON_HALT;
    end else begin
      error_now = pipe_pkg::NO_ERROR;
    end
  end

  // Cause visible from the mem_wb cycle, sticky after it
  assign error_status = (error_q != pipe_pkg::NO_ERROR) ? error_q : error_now;

  always_ff @(posedge clock) begin
    if (reset) begin
      error_q         <= pipe_pkg::NO_ERROR;
      completed_insts <= '0;
    end else begin
      error_q <= error_status;
      if (mem_wb_packet.valid) begin
        completed_insts <= completed_insts + 1'b1;   // HALT counts too
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/pipeline_chk.sv
/* Concurrent checks on the memory bus and the commit port
   Bound into the pipeline top from the testbench */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module pipeline_chk (
  input logic                       clock,
  input logic                       reset,
  input pipe_pkg::bus_cmd_e         proc2mem_command,
  input logic [`PIPE_DATA_W-1:0]    proc2mem_addr,
  input logic [`PIPE_DATA_W-1:0]    proc2mem_data,
  input logic                       mem2proc_valid,
  input logic                       commit_wr_en,
  input logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx
);

  int unsigned fail_count = 0;   // Failed assertions so far

  // Request held steady until answered
  cmd_held: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command != pipe_pkg::BUS_NONE && !mem2proc_valid) |=>
      (proc2mem_command == $past(proc2mem_command) &&
       proc2mem_addr == $past(proc2mem_addr) &&
       proc2mem_data == $past(proc2mem_data)))
    else begin
      $error("bus command changed before its valid pulse");
      fail_count++;
    end

  no_r0_write: assert property (@(posedge clock) disable iff (reset)
    !(commit_wr_en && commit_wr_idx == '0))
    else begin
      $error("commit write enable with index 0");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: testbench/pipeline_tb.sv
/* Directed tests for the five-stage pipeline against an in-order ISA model
   Each test builds a program, runs it to halt and checks every commit */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module pipeline_tb;

  typedef struct packed {
    logic [`PIPE_DATA_W-1:0]    pc;
    logic [`PIPE_REG_IDX_W-1:0] idx;
    logic [`PIPE_DATA_W-1:0]    data;
  } commit_t;

  localparam int MEM_WORDS = 1024;
  localparam int RUN_LIMIT = 3000;   // Cycles before a run counts as hung

  logic                       clock, reset, random_latency;
  logic                       mem2proc_valid, commit_wr_en;
  logic [`PIPE_DATA_W-1:0]    mem2proc_data, proc2mem_addr, proc2mem_data;
  logic [`PIPE_DATA_W-1:0]    completed_insts, commit_wr_data, commit_pc;
  logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx;
  pipe_pkg::bus_cmd_e         proc2mem_command;
  pipe_pkg::error_code_e      error_status;

  logic [31:0]           image [MEM_WORDS];   // Program plus data fill
  int                    prog_len;
  commit_t               exp_q [$];           // Expected register writes
  int                    exp_count;           // Expected completed_insts
  pipe_pkg::error_code_e exp_status;
  string                 test_name;

  pipeline dut0 (.*);
  tb_memory mem0 (.*);
  bind pipeline pipeline_chk chk0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string what, input logic [31:0] exp, act);
    $display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
    abort_run();
  endtask

  task automatic plain_error(input string msg);
    $display("%s: %s", test_name, msg);
    abort_run();
  endtask

  ////////////////////////////////////////////////////////////
  // Program building
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rtype(logic [5:0] op, logic [4:0] rd, ra, rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rd, ra,
                                        logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  task automatic new_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = (i * 4) ^ 32'hDEAD_0000;   // Unique per byte address
    end
    prog_len = 0;
  endtask

  task automatic place(input logic [31:0] inst);   // No spacing
    image[prog_len] = inst;
    prog_len++;
  endtask

  task automatic put(input logic [31:0] inst);     // Three NOPs after
    place(inst);
    repeat (3) place(32'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference ISA model run in order over the image
  ////////////////////////////////////////////////////////////
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] pc, inst, a, b, imm, res, addr;
    logic [5:0]  op;
    logic [4:0]  rd;
    bit          wr;
    mem = image;
    foreach (regs[i]) regs[i] = '0;
    pc = `PIPE_PC_RESET;
    exp_q.delete();
    exp_count  = 0;
    exp_status = pipe_pkg::NO_ERROR;
    while (exp_status == pipe_pkg::NO_ERROR && exp_count < RUN_LIMIT) begin
      inst = mem[pc[11:2]];
      op   = inst[31:26];
      rd   = inst[25:21];
      a    = regs[inst[20:16]];
      b    = regs[inst[15:11]];
      imm  = {{16{inst[15]}}, inst[15:0]};
      addr = a + imm;
      res  = '0;
      wr   = 1'b1;
      exp_count++;
      case (op)
        pipe_pkg::OP_ADD:   res = a + b;
        pipe_pkg::OP_SUB:   res = a - b;
        pipe_pkg::OP_AND:   res = a & b;
        pipe_pkg::OP_OR:    res = a | b;
        pipe_pkg::OP_XOR:   res = a ^ b;
        pipe_pkg::OP_ADDI:  res = a + imm;
        pipe_pkg::OP_LOAD:  res = mem[addr[11:2]];
        pipe_pkg::OP_STORE: begin
          mem[addr[11:2]] = b;
          wr = 1'b0;
        end
        pipe_pkg::OP_NOP:   wr = 1'b0;
        pipe_pkg::OP_HALT: begin
          wr = 1'b0;
          exp_status = pipe_pkg::HALTED_ON_HALT;
        end
        default: begin
          wr = 1'b0;
          exp_status = pipe_pkg::HALTED_ON_ILLEGAL;
        end
      endcase
      if (wr && rd != 0) begin   // r0 stays zero
        regs[rd] = res;
        exp_q.push_back('{pc: pc, idx: rd, data: res});
      end
      pc = pc + 4;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Running and checking
  ////////////////////////////////////////////////////////////
  task automatic apply_reset();
    @(posedge clock);
    #1 reset = 1'b1;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  endtask

  task automatic check_commit();   // Called each cycle at the falling edge
    commit_t exp;
    assert (dut0.chk0.fail_count == 0)
      else plain_error("a bound bus or commit assertion failed");
    assert (!(commit_wr_en && commit_wr_idx == 0))
      else plain_error("commit write enable raised for r0");
    if (commit_wr_en) begin
      assert (exp_q.size() > 0)
        else plain_error($sformatf("unexpected commit at pc %h", commit_pc));
      exp = exp_q.pop_front();
      assert (commit_pc == exp.pc) else value_mismatch("commit_pc", exp.pc, commit_pc);
      assert (commit_wr_idx == exp.idx)
        else value_mismatch("commit_wr_idx", exp.idx, commit_wr_idx);
      assert (commit_wr_data == exp.data)
        else value_mismatch("commit_wr_data", exp.data, commit_wr_data);
    end
  endtask

  task automatic run_and_check(input string name, input bit rand_lat);
    int cycles;
    test_name      = name;
    random_latency = rand_lat;
    run_model();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem0.words[i] = image[i];
    end
    apply_reset();
    cycles = 0;
    do begin                       // Wait for the halt status
      @(negedge clock);
      check_commit();
      cycles++;
      assert (cycles < RUN_LIMIT) else plain_error("no halt status within the cycle limit");
    end while (error_status == pipe_pkg::NO_ERROR);
    assert (exp_q.size() == 0)
      else plain_error($sformatf("halted with %0d commits missing", exp_q.size()));
    assert (error_status == exp_status)
      else value_mismatch("error_status", exp_status, error_status);
    repeat (8) begin               // Bus idle and nothing more commits
      @(negedge clock);
      check_commit();
      assert (proc2mem_command == pipe_pkg::BUS_NONE)
        else plain_error("bus still active after halt");
    end
    assert (error_status == exp_status)
      else value_mismatch("error_status sticky", exp_status, error_status);
    assert (completed_insts == exp_count)
      else value_mismatch("completed_insts", exp_count, completed_insts);
  endtask

  ////////////////////////////////////////////////////////////
  // Programs and tests
  ////////////////////////////////////////////////////////////
  task automatic build_alu();
    new_program();
    put(itype(pipe_pkg::OP_ADDI, 1, 0, 16'd1234));
    put(itype(pipe_pkg::OP_ADDI, 2, 0, 16'hFF9C));    // -100
    put(itype(pipe_pkg::OP_ADDI, 3, 0, 16'h7F0F));
    put(rtype(pipe_pkg::OP_ADD, 4, 1, 2));
    put(rtype(pipe_pkg::OP_SUB, 5, 1, 2));
    put(rtype(pipe_pkg::OP_AND, 6, 3, 2));
    put(rtype(pipe_pkg::OP_OR, 7, 1, 3));
    put(rtype(pipe_pkg::OP_XOR, 8, 7, 2));
    put(itype(pipe_pkg::OP_ADDI, 9, 8, 16'h8001));    // Negative imm
    put(rtype(pipe_pkg::OP_SUB, 10, 2, 4));
    place(itype(pipe_pkg::OP_HALT, 0, 0, 16'd0));
  endtask

  task automatic build_mem();
    new_program();
    put(itype(pipe_pkg::OP_ADDI, 1, 0, 16'h0040));    // Base
    put(itype(pipe_pkg::OP_ADDI, 3, 0, 16'h1111));
    put(itype(pipe_pkg::OP_ADDI, 5, 0, 16'hFFFE));
    put(itype(pipe_pkg::OP_ADDI, 7, 0, 16'h0BAD));
    // Odd rb in the imm top bits adds 0x800 to the store address
    place(itype(pipe_pkg::OP_STORE, 0, 1, {5'd3, 11'd0}));
    place(itype(pipe_pkg::OP_STORE, 0, 1, {5'd5, 11'd4}));
    place(itype(pipe_pkg::OP_STORE, 0, 1, {5'd7, 11'd8}));
    place(itype(pipe_pkg::OP_LOAD, 10, 1, 16'h0800));
    place(itype(pipe_pkg::OP_LOAD, 11, 1, 16'h0804));
    place(itype(pipe_pkg::OP_LOAD, 12, 1, 16'h0808));
    put(itype(pipe_pkg::OP_LOAD, 13, 1, 16'h080C));   // Fill value
    put(rtype(pipe_pkg::OP_XOR, 14, 10, 11));
    place(itype(pipe_pkg::OP_HALT, 0, 0, 16'd0));
  endtask

  task automatic halt_stop();
    new_program();
    put(itype(pipe_pkg::OP_ADDI, 1, 0, 16'd5));
    place(itype(pipe_pkg::OP_HALT, 0, 0, 16'd0));
    place(itype(pipe_pkg::OP_ADDI, 2, 0, 16'd7));     // Must never commit
    place(rtype(pipe_pkg::OP_ADD, 3, 1, 1));
    run_and_check("halt_stop", 1'b1);
  endtask

  task automatic illegal_stop();
    new_program();
    put(itype(pipe_pkg::OP_ADDI, 1, 0, 16'd21));
    put(itype(pipe_pkg::OP_ADDI, 2, 0, 16'd34));
    place(rtype(pipe_pkg::OP_ADD, 3, 1, 2));
    place(32'hFC00_0000);                             // Opcode 63
    place(itype(pipe_pkg::OP_ADDI, 4, 0, 16'd1));
    run_and_check("illegal_stop", 1'b1);
  endtask

  task automatic zero_register();
    new_program();
    put(itype(pipe_pkg::OP_ADDI, 1, 0, 16'd77));
    put(rtype(pipe_pkg::OP_ADD, 0, 1, 1));            // Dropped write
    put(itype(pipe_pkg::OP_ADDI, 0, 0, 16'd5));
    put(itype(pipe_pkg::OP_LOAD, 0, 0, 16'h0900));
    put(rtype(pipe_pkg::OP_ADD, 2, 0, 1));            // 77 if r0 reads zero
    put(rtype(pipe_pkg::OP_OR, 3, 0, 0));
    place(itype(pipe_pkg::OP_HALT, 0, 0, 16'd0));
    run_and_check("zero_register", 1'b0);
  endtask

  initial begin
    reset          = 1'b1;
    random_latency = 1'b0;
    build_alu();
    run_and_check("alu_ops", 1'b0);
    build_mem();
    run_and_check("store_load", 1'b0);
    build_alu();
    run_and_check("alu_ops_random_latency", 1'b1);
    build_mem();
    run_and_check("store_load_random_latency", 1'b1);
    halt_stop();
    illegal_stop();
    zero_register();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_memory.sv
/* Behavioral memory on the pipeline bus, loaded by the testbench
   Answers each held command with one valid pulse after 1 to 4 cycles */
`timescale 1ns/1ns
`default_nettype none
`include "pipe_macros.svh"

module tb_memory (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    random_latency,   // Low gives 1 cycle per access
  input  pipe_pkg::bus_cmd_e      proc2mem_command,
  input  logic [`PIPE_DATA_W-1:0] proc2mem_addr,
  input  logic [`PIPE_DATA_W-1:0] proc2mem_data,
  output logic                    mem2proc_valid,
  output logic [`PIPE_DATA_W-1:0] mem2proc_data
);

  logic [`PIPE_DATA_W-1:0] words [1024];   // 4 KB, indexed by addr[11:2]
  logic [31:0]             lcg_state;
  logic                    busy;           // Access counted down
  logic                    in_reset;
  logic                    use_random;
  int                      wait_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    lcg_state      = 32'd61482;
    busy           = 1'b0;
    wait_left      = 0;
    mem2proc_valid = 1'b0;
    mem2proc_data  = '0;
  end

  always @(posedge clock) begin
    in_reset   = reset;             // Taken at the edge, stable here
    use_random = random_latency;
    #1;
    mem2proc_valid = 1'b0;          // Pulse lasts one cycle
    mem2proc_data  = '0;
    if (in_reset) begin
      busy = 1'b0;
    end else if (proc2mem_command != pipe_pkg::BUS_NONE) begin
      if (!busy) begin              // New request
        busy = 1'b1;
        wait_left = 1;
        if (use_random) begin
          lcg_state = lcg_next(lcg_state);
          wait_left = 1 + lcg_state[17:16];
        end
      end
      wait_left = wait_left - 1;
      if (wait_left == 0) begin
        busy           = 1'b0;
        mem2proc_valid = 1'b1;
        if (proc2mem_command == pipe_pkg::BUS_STORE) begin
          words[proc2mem_addr[11:2]] = proc2mem_data;
        end else begin
          mem2proc_data = words[proc2mem_addr[11:2]];
        end
      end
    end
  end

endmodule

`default_nettype wire
